//--- logic/huffman_pkg.sv
/*
 * Shared sizes, types and emit-order tables for the Huffman code generator.
 * Every module imports this package; nodes 0..7 are the input symbols,
 * node 8+j is the node made by merge j.
 */
package huffman_pkg;

    // ============================================================
    // sizes
    // ============================================================
    localparam int sym_count    = 8;
    localparam int node_count   = 15;
    localparam int merge_count  = 7;
    localparam int emit_count   = 5;
    localparam int max_code_len = 7;

    // ============================================================
    // scalar types
    // ============================================================
    typedef logic [2:0] in_weight_t;
    typedef logic [5:0] node_weight_t;  // 8 x 7 = 56 fits
    typedef logic [sym_count-1:0] sym_mask_t;
    typedef logic [3:0] node_idx_t;
    typedef logic [2:0] sym_idx_t;
    typedef logic [2:0] merge_idx_t;
    typedef logic [max_code_len-1:0] code_t;
    typedef logic [2:0] code_len_t;

    // one tree node of 15 bits
    typedef struct packed {
        node_weight_t weight;
        sym_mask_t    symbols;
        logic         live;
    } node_t;

    // the two lowest-ranked live nodes
    typedef struct packed {
        node_idx_t lo;
        node_idx_t next;
    } pair_t;

    // symbol sent at each emit position, per mode
    localparam sym_idx_t emit_order_mode0 [emit_count] = '{3'd4, 3'd5, 3'd6, 3'd7, 3'd3};
    localparam sym_idx_t emit_order_mode1 [emit_count] = '{3'd4, 3'd2, 3'd5, 3'd0, 3'd1};

endpackage

//--- logic/huffman_ctrl.sv
/*
 * Phase sequencer for the Huffman code generator.
 * Walks idle -> load -> merge -> emit and numbers the incoming symbols
 * and the seven merges. Strobes are decoded from the phase register.
 */
`timescale 1ns/1ps

module huffman_ctrl (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    in_valid,
    input  logic                    emit_done,
    output logic                    start,
    output logic                    load_en,
    output huffman_pkg::sym_idx_t   load_idx,
    output logic                    merge_en,
    output huffman_pkg::merge_idx_t merge_idx,
    output logic                    emit_en,
    output logic                    clear
);
    import huffman_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_load,
        st_merge,
        st_emit
    } phase_t;

    phase_t     state, state_nxt;
    sym_idx_t   load_cnt;
    merge_idx_t merge_cnt;

    // ============================================================
    // phase FSM
    // ============================================================
    always_comb begin
        state_nxt = state;
        case (state)
            st_idle:  if (in_valid) state_nxt = st_load;
            st_load:  if (in_valid && load_cnt == sym_idx_t'(sym_count - 1)) state_nxt = st_merge;
            st_merge: if (merge_cnt == merge_idx_t'(merge_count - 1)) state_nxt = st_emit;
            st_emit:  if (emit_done) state_nxt = st_idle;
            default:  state_nxt = st_idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= st_idle;
            load_cnt  <= '0;
            merge_cnt <= '0;
            clear     <= 1'b0;
        end else begin
            state <= state_nxt;
            if (load_en)
                load_cnt <= load_cnt + 3'd1;  // wraps to 0 after symbol 7
            if (clear)
                merge_cnt <= '0;
            else if (merge_en)
                merge_cnt <= merge_cnt + 3'd1;
            clear <= emit_en && emit_done;  // one cycle after the last bit
        end
    end

    // strobes
    assign start     = (state == st_idle) && in_valid;
    assign load_en   = ((state == st_idle) || (state == st_load)) && in_valid;
    assign load_idx  = load_cnt;
    assign merge_en  = (state == st_merge);
    assign merge_idx = merge_cnt;
    assign emit_en   = (state == st_emit);

endmodule

//--- logic/node_table.sv
/*
 * Weight and symbol-set storage for the fifteen tree nodes.
 * Symbol nodes are written as weights arrive; each merge writes node
 * 8+merge_idx from the selected pair and retires both children.
 */
`timescale 1ns/1ps

module node_table (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    start,
    input  logic                    load_en,
    input  huffman_pkg::sym_idx_t   load_idx,
    input  huffman_pkg::in_weight_t in_weight,
    input  logic                    merge_en,
    input  huffman_pkg::merge_idx_t merge_idx,
    input  huffman_pkg::pair_t      pair,
    output huffman_pkg::node_t      nodes [huffman_pkg::node_count]
);
    import huffman_pkg::*;

    node_weight_t          weight_q [node_count];
    sym_mask_t             sym_q [node_count];
    logic [node_count-1:0] live_q;
    node_idx_t             new_idx;

    assign new_idx = {1'b1, merge_idx};  // 8 + j

    // live flags
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            live_q <= '0;
        end else if (start) begin
            live_q <= node_count'((1 << sym_count) - 1);  // leaves only
        end else if (merge_en) begin
            live_q[pair.lo]   <= 1'b0;
            live_q[pair.next] <= 1'b0;
            live_q[new_idx]   <= 1'b1;
        end
    end

    // node payload
    always_ff @(posedge clk) begin
        if (start) begin
            for (int s = 0; s < sym_count; s++) begin
                sym_q[s] <= sym_mask_t'(1 << s);  // one-hot leaf sets
            end
        end
        if (load_en)
            weight_q[load_idx] <= {3'b000, in_weight};
        if (merge_en) begin
            weight_q[new_idx] <= weight_q[pair.lo] + weight_q[pair.next];
            sym_q[new_idx]    <= sym_q[pair.lo] | sym_q[pair.next];
        end
    end

    always_comb begin
        for (int i = 0; i < node_count; i++) begin
            nodes[i].weight  = weight_q[i];
            nodes[i].symbols = sym_q[i];
            nodes[i].live    = live_q[i];
        end
    end

endmodule

//--- logic/pair_selector.sv
/*
 * Finds the two lowest-ranked live nodes of the table, combinationally.
 * Smaller weight ranks lower; on equal weight the higher node number
 * ranks lower. Feeds the merge in node_table and code_builder.
 */
`timescale 1ns/1ps

module pair_selector (
    input  huffman_pkg::node_t nodes [huffman_pkg::node_count],
    output huffman_pkg::pair_t pair
);
    import huffman_pkg::*;

    // ============================================================
    // two-pass scan
    // ============================================================
    // scanning upward with <= lets a later equal-weight node take over,
    // which gives the higher-number tie preference
    always_comb begin
        node_weight_t lo_w;
        node_weight_t next_w;

        lo_w      = '1;  // above any reachable weight
        next_w    = '1;
        pair.lo   = '0;
        pair.next = '0;

        // lowest
        for (int i = 0; i < node_count; i++) begin
            if (nodes[i].live && nodes[i].weight <= lo_w) begin
                lo_w    = nodes[i].weight;
                pair.lo = node_idx_t'(i);
            end
        end

        // second lowest, skipping the winner
        for (int i = 0; i < node_count; i++) begin
            if (nodes[i].live && node_idx_t'(i) != pair.lo
                && nodes[i].weight <= next_w) begin
                next_w    = nodes[i].weight;
                pair.next = node_idx_t'(i);
            end
        end
    end

endmodule

//--- logic/code_builder.sv
/*
 * Per-symbol code bits and code lengths, grown by one bit per merge.
 * Symbols under the lower-ranked child take a 1, those under the other
 * child take a 0. New bits enter at bit 0, so bit 0 ends as the root bit.
 */
`timescale 1ns/1ps

module code_builder (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   start,
    input  logic                   merge_en,
    input  huffman_pkg::node_t     nodes [huffman_pkg::node_count],
    input  huffman_pkg::pair_t     pair,
    output huffman_pkg::code_t     codes [huffman_pkg::sym_count],
    output huffman_pkg::code_len_t lens [huffman_pkg::sym_count]
);
    import huffman_pkg::*;

    sym_mask_t lo_syms;
    sym_mask_t next_syms;

    assign lo_syms   = nodes[pair.lo].symbols;
    assign next_syms = nodes[pair.next].symbols;

    // code lengths
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int s = 0; s < sym_count; s++) lens[s] <= '0;
        end else if (start) begin
            for (int s = 0; s < sym_count; s++) lens[s] <= '0;
        end else if (merge_en) begin
            for (int s = 0; s < sym_count; s++) begin
                if (lo_syms[s] || next_syms[s])
                    lens[s] <= lens[s] + 3'd1;
            end
        end
    end

    // code bits, shifted up
    always_ff @(posedge clk) begin
        if (start) begin
            for (int s = 0; s < sym_count; s++) codes[s] <= '0;
        end else if (merge_en) begin
            for (int s = 0; s < sym_count; s++) begin
                if (lo_syms[s])
                    codes[s] <= {codes[s][max_code_len-2:0], 1'b1};
                else if (next_syms[s])
                    codes[s] <= {codes[s][max_code_len-2:0], 1'b0};
            end
        end
    end

endmodule

//--- logic/code_serializer.sv
/*
 * Bit-serial output of the five selected codes.
 * The mode is latched on start; while emit_en is high one bit goes out
 * per cycle, bit 0 first, and emit_done marks the final bit.
 */
`timescale 1ns/1ps

module code_serializer (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   start,
    input  logic                   out_mode,
    input  logic                   emit_en,
    input  huffman_pkg::code_t     codes [huffman_pkg::sym_count],
    input  huffman_pkg::code_len_t lens [huffman_pkg::sym_count],
    output logic                   emit_done,
    output logic                   out_valid,
    output logic                   out_code
);
    import huffman_pkg::*;

    logic       mode_q;
    logic [2:0] pos_q;    // emit position 0..4
    code_len_t  bit_q;    // bit within current code
    sym_idx_t   cur_sym;
    logic       last_bit;

    assign cur_sym   = mode_q ? emit_order_mode1[pos_q] : emit_order_mode0[pos_q];
    assign last_bit  = (bit_q == lens[cur_sym] - 3'd1);
    assign emit_done = emit_en && last_bit && (pos_q == 3'(emit_count - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mode_q <= 1'b0;
            pos_q  <= '0;
            bit_q  <= '0;
        end else begin
            if (start)
                mode_q <= out_mode;
            if (emit_en) begin
                if (emit_done) begin
                    pos_q <= '0;
                    bit_q <= '0;
                end else if (last_bit) begin
                    pos_q <= pos_q + 3'd1;  // next symbol
                    bit_q <= '0;
                end else begin
                    bit_q <= bit_q + 3'd1;
                end
            end
        end
    end

    assign out_valid = emit_en;
    assign out_code  = emit_en & codes[cur_sym][bit_q];  // 0 when idle

endmodule

//--- logic/huffman_top.sv
/*
 * Top level of the Huffman code generator.
 * Eight 3-bit weights in, one per cycle under in_valid; five codes out,
 * one bit per cycle under out_valid, order chosen by out_mode.
 */
`timescale 1ns/1ps

module huffman_top (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    in_valid,
    input  huffman_pkg::in_weight_t in_weight,
    input  logic                    out_mode,
    output logic                    out_valid,
    output logic                    out_code
);
    import huffman_pkg::*;

    logic       start;
    logic       load_en;
    sym_idx_t   load_idx;
    logic       merge_en;
    merge_idx_t merge_idx;
    logic       emit_en;
    logic       emit_done;
    node_t      nodes [node_count];
    pair_t      pair;
    code_t      codes [sym_count];
    code_len_t  lens [sym_count];

    // ============================================================
    // control and datapath
    // ============================================================
    huffman_ctrl u_ctrl (
        .clk(clk), .rst_n(rst_n), .in_valid(in_valid), .emit_done(emit_done),
        .start(start), .load_en(load_en), .load_idx(load_idx),
        .merge_en(merge_en), .merge_idx(merge_idx), .emit_en(emit_en), .clear()
    );

    node_table u_nodes (
        .clk(clk), .rst_n(rst_n), .start(start), .load_en(load_en),
        .load_idx(load_idx), .in_weight(in_weight), .merge_en(merge_en),
        .merge_idx(merge_idx), .pair(pair), .nodes(nodes)
    );

    pair_selector u_select (.nodes(nodes), .pair(pair));

    code_builder u_codes (
        .clk(clk), .rst_n(rst_n), .start(start), .merge_en(merge_en),
        .nodes(nodes), .pair(pair), .codes(codes), .lens(lens)
    );

    code_serializer u_out (
        .clk(clk), .rst_n(rst_n), .start(start), .out_mode(out_mode),
        .emit_en(emit_en), .codes(codes), .lens(lens), .emit_done(emit_done),
        .out_valid(out_valid), .out_code(out_code)
    );

endmodule

//--- sim/huffman_chk.sv
/*
 * Concurrent protocol checks for the Huffman code generator.
 * Bound into huffman_top; the testbench reads fail_count at the end.
 */
`timescale 1ns/1ps

module huffman_chk (
    input logic clk,
    input logic rst_n,
    input logic in_valid,
    input logic out_valid,
    input logic out_code
);
    int   fail_count = 0;
    logic seen_frame;  // set once the first weight arrives

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            seen_frame <= 1'b0;
        else if (in_valid)
            seen_frame <= 1'b1;
    end

    // ============================================================
    // output protocol
    // ============================================================
    // quiet through reset and until the first frame
    a_quiet_start: assert property (@(posedge clk)
        !seen_frame |-> !out_valid && !out_code) else begin
        $error("output active before the first frame");
        fail_count++;
    end

    a_code_idle: assert property (@(posedge clk) disable iff (!rst_n)
        !out_valid |-> !out_code) else begin
        $error("out_code high while out_valid is low");
        fail_count++;
    end

    // first output bit 8 cycles after the last weight
    a_valid_rise: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(in_valid) |-> !out_valid [*7] ##1 $rose(out_valid)) else begin
        $error("out_valid did not rise 8 cycles after the last weight");
        fail_count++;
    end

endmodule

bind huffman_top huffman_chk u_chk (
    .clk(clk), .rst_n(rst_n), .in_valid(in_valid), .out_valid(out_valid), .out_code(out_code)
);

//--- sim/huffman_tb.sv
/*
 * Testbench for the Huffman code generator. Sends frames of eight weights,
 * rebuilds the tree and the emit stream in a reference model, and compares
 * the serial output. Protocol timing is checked by the bound huffman_chk.
 */
`timescale 1ns/1ps

module huffman_tb;
    logic        clk = 1'b0;
    logic        rst_n;
    logic        in_valid;
    logic [2:0]  in_weight;
    logic        out_mode;
    logic        out_valid;
    logic        out_code;
    logic [31:0] lfsr = 32'he6d102b2;
    logic [63:0] exp_bits;
    int          exp_len;
    int          tests = 0;
    int          failed = 0;
    // reference model where node 8+j is made by merge j
    int          m_weight [15];
    logic        m_live [15];
    logic [7:0]  m_syms [15];
    logic [6:0]  m_code [8];
    int          m_len [8];
    // emit order per mode with position 0 in the low bits
    localparam logic [14:0] order0 = {3'd3, 3'd7, 3'd6, 3'd5, 3'd4};
    localparam logic [14:0] order1 = {3'd1, 3'd0, 3'd5, 3'd2, 3'd4};

    always #2 clk = ~clk;  // 4 ns period

    huffman_top dut (.*);

    // ============================================================
    // reference model
    // ============================================================
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    // downward scan with strict compare, so ties keep the higher number
    function automatic int pick_lowest(input int skip);
        int best;
        best = -1;
        for (int i = 14; i >= 0; i--) begin
            if (m_live[i] && i != skip && (best < 0 || m_weight[i] < m_weight[best]))
                best = i;
        end
        return best;
    endfunction

    task automatic build_model(input logic [23:0] w, input logic mode);
        int lo;
        int nx;
        int s;
        for (int i = 0; i < 15; i++) begin
            m_live[i]   = (i < 8);  // leaves start live
            m_weight[i] = int'((w >> (3 * i)) & 24'o7);
            m_syms[i]   = 8'(1 << i);  // zero past the leaves
        end
        for (int k = 0; k < 8; k++) begin
            m_code[k] = '0;
            m_len[k]  = 0;
        end
        for (int j = 0; j < 7; j++) begin
            lo = pick_lowest(-1);
            nx = pick_lowest(lo);
            m_weight[8+j] = m_weight[lo] + m_weight[nx];
            m_syms[8+j]   = m_syms[lo] | m_syms[nx];
            m_live[8+j]   = 1'b1;
            m_live[lo]    = 1'b0;
            m_live[nx]    = 1'b0;
            for (int k = 0; k < 8; k++) begin
                if (m_syms[8+j][k]) begin
                    m_code[k] = {m_code[k][5:0], m_syms[lo][k]};  // 1 under lo
                    m_len[k]++;
                end
            end
        end
        exp_bits = '0;
        exp_len  = 0;
        for (int p = 0; p < 5; p++) begin
            s = mode ? order1[3*p +: 3] : order0[3*p +: 3];
            for (int b = 0; b < m_len[s]; b++) begin
                exp_bits[exp_len] = m_code[s][b];  // root bit first
                exp_len++;
            end
        end
    endtask

    // ============================================================
    // stimulus and collection
    // ============================================================
    // drive and sample points sit 1 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic run_test(input string name, input logic [23:0] w, input logic mode);
        logic [63:0] act_bits;
        int          act_len;
        int          waited;
        logic        ok;
        build_model(w, mode);
        for (int k = 0; k < 8; k++) begin
            in_valid  = 1'b1;
            in_weight = w[3*k +: 3];
            out_mode  = (k == 0) ? mode : ~mode;  // only the first cycle counts
            next_cycle();
        end
        in_valid = 1'b0;
        act_bits = '0;
        act_len  = 0;
        waited   = 0;
        while (!out_valid && waited < 40) begin
            next_cycle();
            waited++;
        end
        while (out_valid && act_len < 64) begin
            act_bits[act_len] = out_code;
            act_len++;
            next_cycle();
        end
        ok = !out_valid && act_len > 0;
        if (!ok)
            $display("%s: timed out waiting for a complete out_valid run", name);
        a_len: assert (act_len == exp_len) else begin
            $display("** Error %s: run length expected %0d actual %0d", name, exp_len, act_len);
            ok = 1'b0;
        end
        a_bits: assert (act_bits == exp_bits) else begin
            $display("** Error %s: stream expected %h actual %h", name, exp_bits, act_bits);
            ok = 1'b0;
        end
        tests++;
        if (!ok)
            failed++;
        $display("%s: %s", name, ok ? "ok" : "mismatch");
    endtask

    initial begin
        logic [23:0] w;
        rst_n     = 1'b0;
        in_valid  = 1'b0;
        in_weight = '0;
        out_mode  = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;
        repeat (4) next_cycle();
        run_test("mode0_distinct", 24'o10726354, 1'b0);
        next_cycle();
        for (int t = 0; t < 3; t++) begin
            w = '0;
            for (int i = 0; i < 21; i++) begin
                w[i] = lfsr[0];
                lfsr = lfsr_next(lfsr);
            end
            w[23:21] = w[2:0];  // symbols 0 and 7 tie
            run_test($sformatf("mode1_random%0d", t), w, 1'b1);
            next_cycle();
        end
        run_test("all_equal", 24'o33333333, 1'b0);
        next_cycle();
        run_test("all_seven", 24'o77777777, 1'b1);
        next_cycle();
        run_test("b2b_first", 24'o56012347, 1'b1);
        run_test("b2b_second", 24'o21432765, 1'b0);  // cycle after out_valid falls
        $display("%0d tests, %0d passed, %0d failed, %0d protocol failures",
                 tests, tests - failed, failed, dut.u_chk.fail_count);
        if (failed == 0 && dut.u_chk.fail_count == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

//--- compile.f
logic/huffman_pkg.sv
logic/huffman_ctrl.sv
logic/node_table.sv
logic/pair_selector.sv
logic/code_builder.sv
logic/code_serializer.sv
logic/huffman_top.sv
sim/huffman_chk.sv
sim/huffman_tb.sv
